/* common/fetch_settings.svh */
/*
 * Widths, cache geometry and queue depths of the fetch front end.
 * Sizes are in bytes and must be powers of two.
 * The line size must be a whole number of instruction words.
 */

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and instruction words
`define FETCH_ADDR_WIDTH 32
`define FETCH_INSN_WIDTH 32

// Direct-mapped instruction cache, 8 words per line
`define FETCH_IC_CACHE_SIZE 1024
`define FETCH_IC_LINE_SIZE 32

// Queue depths, both at least 2
`define FETCH_INSN_FIFO_DEPTH 8
`define FETCH_IFQ_DEPTH 2

`endif

/* common/fetch_pkg.sv */
/*
 * Types shared by the fetch front end and its testbench.
 * A line holds the instruction at the lowest address in its lowest word.
 */

`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`FETCH_INSN_WIDTH-1:0] insn_t;
    typedef logic [`FETCH_IC_LINE_SIZE*8-1:0] line_t;

    // Instruction FIFO payload
    typedef struct packed {
        addr_t pc;
        insn_t insn;
    } fetch_entry_t;

    // NEXT_FETCH streams, IFQ_ENQUEUE hands a miss to the IFQ,
    // IFQ_STALL waits for the fill, FIFO_STALL waits for FIFO room
    typedef enum logic [1:0] {
        NEXT_FETCH  = 2'b00,
        IFQ_ENQUEUE = 2'b01,
        IFQ_STALL   = 2'b10,
        FIFO_STALL  = 2'b11
    } fetch_state_t;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
/*
 * Synchronous FIFO with flush. DEPTH must be at least 2.
 * The head is shown combinationally; a write into a full FIFO is ignored.
 */

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH  = 8,
    parameter type T_DATA = logic [31:0]
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_flush,
    input  logic  i_we,
    input  T_DATA i_wdata,
    output logic  o_full,
    input  logic  i_ack,
    output T_DATA o_rdata,
    output logic  o_empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_DATA             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_r;
    logic [PTR_W-1:0]  rd_ptr_r;
    logic [CNT_W-1:0]  count_r;
    logic              wr;
    logic              rd;

    assign o_full  = (count_r == CNT_W'(DEPTH));
    assign o_empty = (count_r == '0);
    assign wr      = i_we & ~o_full;
    assign rd      = i_ack & ~o_empty;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (wr) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (rd) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            count_r <= count_r + CNT_W'(wr) - CNT_W'(rd);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr_r] <= i_wdata;
        end
    end

    assign o_rdata = mem[rd_ptr_r];

endmodule

`default_nettype wire

/* source/ifq.sv */
/*
 * Miss queue in front of the line memory, one read outstanding at a time.
 * An allocation for the line already in flight is dropped.
 * The fill comes out in the same cycle as the memory response.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module ifq (
    input  logic             clk,
    input  logic             i_rst_n,

    // Miss allocation from fetch control
    input  logic             i_alloc_en,
    input  fetch_pkg::addr_t i_alloc_addr,
    output logic             o_full,

    // Line memory
    output logic             o_mem_req,
    output fetch_pkg::addr_t o_mem_addr,
    input  logic             i_mem_rsp,
    input  fetch_pkg::line_t i_mem_data,

    // Fill toward cache and fetch control
    output logic             o_fill_en,
    output fetch_pkg::addr_t o_fill_addr,
    output fetch_pkg::line_t o_fill_data
);

    fetch_pkg::addr_t alloc_line;
    logic             alloc_dup;
    logic             queue_we;
    logic             queue_empty;
    fetch_pkg::addr_t queue_head;
    logic             issue;

    logic             busy_r;
    logic             req_r;
    fetch_pkg::addr_t line_addr_r;

    assign alloc_line = i_alloc_addr & ~fetch_pkg::addr_t'(`FETCH_IC_LINE_SIZE - 1);

    // A response this cycle ends the flight, so a late duplicate is queued
    assign alloc_dup = busy_r & ~i_mem_rsp & (alloc_line == line_addr_r);
    assign queue_we  = i_alloc_en & ~alloc_dup;

    sync_fifo #(
        .DEPTH  (`FETCH_IFQ_DEPTH),
        .T_DATA (fetch_pkg::addr_t)
    ) u_miss_fifo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_flush (1'b0),
        .i_we    (queue_we),
        .i_wdata (alloc_line),
        .o_full  (o_full),
        .i_ack   (issue),
        .o_rdata (queue_head),
        .o_empty (queue_empty)
    );

    assign issue = ~busy_r & ~queue_empty;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            req_r  <= 1'b0;
        end else begin
            req_r <= issue;
            if (issue) begin
                busy_r <= 1'b1;
            end else if (i_mem_rsp) begin
                busy_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            line_addr_r <= queue_head;
        end
    end

    assign o_mem_req   = req_r;
    assign o_mem_addr  = line_addr_r;
    assign o_fill_en   = busy_r & i_mem_rsp;
    assign o_fill_addr = line_addr_r;
    assign o_fill_data = i_mem_data;

endmodule

`default_nettype wire

/* fetch/icache.sv */
/*
 * Direct-mapped instruction cache with one cycle lookup latency.
 * A fill that matches the lookup line in the same cycle is forwarded.
 * Only valid bits are reset; tags and data come up undefined.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module icache (
    input  logic             clk,
    input  logic             i_rst_n,

    // Lookup, answered at the next edge
    input  logic             i_lookup_en,
    input  fetch_pkg::addr_t i_lookup_addr,
    output logic             o_hit,
    output fetch_pkg::insn_t o_data,

    // Line fill from the IFQ
    input  logic             i_fill_en,
    input  fetch_pkg::addr_t i_fill_addr,
    input  fetch_pkg::line_t i_fill_data
);

    localparam int NUM_LINES = `FETCH_IC_CACHE_SIZE / `FETCH_IC_LINE_SIZE;
    localparam int WORDS     = `FETCH_IC_LINE_SIZE / (`FETCH_INSN_WIDTH / 8);
    localparam int OFFSET_W  = $clog2(`FETCH_IC_LINE_SIZE);
    localparam int WORD_W    = $clog2(WORDS);
    localparam int BYTE_W    = OFFSET_W - WORD_W;
    localparam int INDEX_W   = $clog2(NUM_LINES);
    localparam int TAG_W     = `FETCH_ADDR_WIDTH - INDEX_W - OFFSET_W;

    logic [TAG_W-1:0]   tag_mem [NUM_LINES];
    fetch_pkg::line_t   data_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_r;

    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   lookup_tag;
    logic [WORD_W-1:0]  lookup_word;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;

    logic               line_hit;
    logic               fill_fwd;
    fetch_pkg::line_t   lookup_line;

    logic               hit_r;
    fetch_pkg::insn_t   data_r;

    // Address split: tag, line index, word within the line
    assign lookup_index = i_lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag   = i_lookup_addr[OFFSET_W+INDEX_W +: TAG_W];
    assign lookup_word  = i_lookup_addr[BYTE_W +: WORD_W];
    assign fill_index   = i_fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag     = i_fill_addr[OFFSET_W+INDEX_W +: TAG_W];

    assign line_hit = valid_r[lookup_index] & (tag_mem[lookup_index] == lookup_tag);

    // Bypass the line being written this cycle
    assign fill_fwd    = i_fill_en & (fill_index == lookup_index) & (fill_tag == lookup_tag);
    assign lookup_line = fill_fwd ? i_fill_data : data_mem[lookup_index];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_r <= '0;
            hit_r   <= 1'b0;
        end else begin
            hit_r <= i_lookup_en & (line_hit | fill_fwd);
            if (i_fill_en) begin
                valid_r[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= i_fill_data;
        end
        if (i_lookup_en) begin
            data_r <= lookup_line[lookup_word*`FETCH_INSN_WIDTH +: `FETCH_INSN_WIDTH];
        end
    end

    assign o_hit  = hit_r;
    assign o_data = data_r;

endmodule

`default_nettype wire

/* fetch/fetch_ctrl.sv */
/*
 * Fetch control with PC register and the IT (lookup) and IR (result) stages.
 * A miss or a full FIFO stops fetch and restarts it from the blocked PC.
 * A fill for another line restarts fetch too; the PC then simply misses again.
 * The decoder output is valid one cycle after the FIFO ack.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic                   clk,
    input  logic                   i_rst_n,

    input  logic                   i_redirect,
    input  fetch_pkg::addr_t       i_redirect_addr,
    input  logic                   i_decode_stall,

    // Cache lookup
    output logic                   o_ic_lookup_en,
    output fetch_pkg::addr_t       o_ic_lookup_addr,
    input  logic                   i_ic_hit,
    input  fetch_pkg::insn_t       i_ic_data,

    // Instruction FIFO
    output logic                   o_fifo_we,
    output fetch_pkg::fetch_entry_t o_fifo_wdata,
    input  logic                   i_fifo_full,
    input  logic                   i_fifo_empty,
    input  fetch_pkg::fetch_entry_t i_fifo_rdata,
    output logic                   o_fifo_ack,

    // Miss queue
    output logic                   o_ifq_alloc_en,
    output fetch_pkg::addr_t       o_ifq_alloc_addr,
    input  logic                   i_ifq_full,
    input  logic                   i_fill_en,

    // Decoder
    output logic                   o_fetch_valid,
    output fetch_pkg::addr_t       o_fetch_pc,
    output fetch_pkg::insn_t       o_fetch_insn
);

    fetch_pkg::fetch_state_t state_r;
    fetch_pkg::fetch_state_t state_next;

    fetch_pkg::addr_t pc_r;
    fetch_pkg::addr_t pc_next;
    fetch_pkg::addr_t miss_pc_r;

    logic             fetch_active;
    logic             it_valid;
    logic             ir_valid_r;
    fetch_pkg::addr_t ir_addr_r;
    logic             ir_valid;
    logic             ir_miss;
    logic             ir_block;
    logic             ir_stall;

    logic             fetch_valid_r;
    fetch_pkg::addr_t fetch_pc_r;
    fetch_pkg::insn_t fetch_insn_r;

    assign fetch_active = (state_r == fetch_pkg::NEXT_FETCH);

    // IR result, blocked either by a miss or by a full FIFO
    assign ir_valid = ir_valid_r & fetch_active;
    assign ir_miss  = ir_valid & ~i_ic_hit;
    assign ir_block = ir_valid & i_ic_hit & i_fifo_full;
    assign ir_stall = ir_miss | ir_block;

    // The IT lookup is dropped when IR stalls, it restarts from the saved PC
    assign it_valid         = fetch_active & ~i_redirect & ~ir_stall;
    assign o_ic_lookup_en   = it_valid;
    assign o_ic_lookup_addr = pc_r;

    assign o_fifo_we    = ir_valid & i_ic_hit & ~i_fifo_full & ~i_redirect;
    assign o_fifo_wdata = '{pc: ir_addr_r, insn: i_ic_data};

    assign o_ifq_alloc_en   = (state_r == fetch_pkg::IFQ_ENQUEUE) & ~i_ifq_full & ~i_redirect;
    assign o_ifq_alloc_addr = miss_pc_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            fetch_pkg::NEXT_FETCH: begin
                if (ir_miss) begin
                    state_next = fetch_pkg::IFQ_ENQUEUE;
                end else if (ir_block) begin
                    state_next = fetch_pkg::FIFO_STALL;
                end
            end
            fetch_pkg::IFQ_ENQUEUE: begin
                if (!i_ifq_full) begin
                    state_next = fetch_pkg::IFQ_STALL;
                end
            end
            fetch_pkg::IFQ_STALL: begin
                if (i_fill_en) begin
                    state_next = i_fifo_full ? fetch_pkg::FIFO_STALL : fetch_pkg::NEXT_FETCH;
                end
            end
            default: begin
                if (!i_fifo_full) begin
                    state_next = fetch_pkg::NEXT_FETCH;
                end
            end
        endcase

        if (i_redirect) begin
            state_next = fetch_pkg::NEXT_FETCH;
        end
    end

    // PC mux, stall states keep reloading the blocked PC
    always_comb begin
        case (state_r)
            fetch_pkg::NEXT_FETCH:  pc_next = it_valid ? pc_r + 4 : pc_r;
            fetch_pkg::IFQ_ENQUEUE: pc_next = pc_r;
            default:                pc_next = miss_pc_r;
        endcase

        if (i_redirect) begin
            pc_next = i_redirect_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r       <= fetch_pkg::NEXT_FETCH;
            pc_r          <= '0;
            ir_valid_r    <= 1'b0;
            fetch_valid_r <= 1'b0;
        end else begin
            state_r       <= state_next;
            pc_r          <= pc_next;
            ir_valid_r    <= it_valid;
            fetch_valid_r <= o_fifo_ack;
        end
    end

    always_ff @(posedge clk) begin
        ir_addr_r <= pc_r;
        if (ir_stall && !i_redirect) begin
            miss_pc_r <= ir_addr_r;
        end
        if (o_fifo_ack) begin
            fetch_pc_r   <= i_fifo_rdata.pc;
            fetch_insn_r <= i_fifo_rdata.insn;
        end
    end

    // Pop toward the decoder; an entry shown during a redirect is stale
    assign o_fifo_ack    = ~i_fifo_empty & ~i_decode_stall & ~i_redirect;
    assign o_fetch_valid = fetch_valid_r & ~i_redirect;
    assign o_fetch_pc    = fetch_pc_r;
    assign o_fetch_insn  = fetch_insn_r;

endmodule

`default_nettype wire

/* source/fetch_top.sv */
/*
 * Fetch front end: control, instruction cache, miss queue and
 * instruction FIFO. A redirect flushes the FIFO but not pending misses.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_top (
    input  logic             clk,
    input  logic             i_rst_n,

    input  logic             i_redirect,
    input  fetch_pkg::addr_t i_redirect_addr,

    // Decoder
    input  logic             i_decode_stall,
    output logic             o_fetch_valid,
    output fetch_pkg::addr_t o_fetch_pc,
    output fetch_pkg::insn_t o_fetch_insn,

    // Line memory
    output logic             o_mem_req,
    output fetch_pkg::addr_t o_mem_addr,
    input  logic             i_mem_rsp,
    input  fetch_pkg::line_t i_mem_data
);

    logic                    ic_lookup_en;
    fetch_pkg::addr_t        ic_lookup_addr;
    logic                    ic_hit;
    fetch_pkg::insn_t        ic_data;

    logic                    fifo_we;
    fetch_pkg::fetch_entry_t fifo_wdata;
    logic                    fifo_full;
    logic                    fifo_empty;
    fetch_pkg::fetch_entry_t fifo_rdata;
    logic                    fifo_ack;

    logic                    ifq_alloc_en;
    fetch_pkg::addr_t        ifq_alloc_addr;
    logic                    ifq_full;

    logic                    fill_en;
    fetch_pkg::addr_t        fill_addr;
    fetch_pkg::line_t        fill_data;

    fetch_ctrl u_fetch_ctrl (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_redirect       (i_redirect),
        .i_redirect_addr  (i_redirect_addr),
        .i_decode_stall   (i_decode_stall),
        .o_ic_lookup_en   (ic_lookup_en),
        .o_ic_lookup_addr (ic_lookup_addr),
        .i_ic_hit         (ic_hit),
        .i_ic_data        (ic_data),
        .o_fifo_we        (fifo_we),
        .o_fifo_wdata     (fifo_wdata),
        .i_fifo_full      (fifo_full),
        .i_fifo_empty     (fifo_empty),
        .i_fifo_rdata     (fifo_rdata),
        .o_fifo_ack       (fifo_ack),
        .o_ifq_alloc_en   (ifq_alloc_en),
        .o_ifq_alloc_addr (ifq_alloc_addr),
        .i_ifq_full       (ifq_full),
        .i_fill_en        (fill_en),
        .o_fetch_valid    (o_fetch_valid),
        .o_fetch_pc       (o_fetch_pc),
        .o_fetch_insn     (o_fetch_insn)
    );

    icache u_icache (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_lookup_en   (ic_lookup_en),
        .i_lookup_addr (ic_lookup_addr),
        .o_hit         (ic_hit),
        .o_data        (ic_data),
        .i_fill_en     (fill_en),
        .i_fill_addr   (fill_addr),
        .i_fill_data   (fill_data)
    );

    ifq u_ifq (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_alloc_en   (ifq_alloc_en),
        .i_alloc_addr (ifq_alloc_addr),
        .o_full       (ifq_full),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_rsp    (i_mem_rsp),
        .i_mem_data   (i_mem_data),
        .o_fill_en    (fill_en),
        .o_fill_addr  (fill_addr),
        .o_fill_data  (fill_data)
    );

    sync_fifo #(
        .DEPTH  (`FETCH_INSN_FIFO_DEPTH),
        .T_DATA (fetch_pkg::fetch_entry_t)
    ) u_insn_fifo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_redirect),
        .i_we    (fifo_we),
        .i_wdata (fifo_wdata),
        .o_full  (fifo_full),
        .i_ack   (fifo_ack),
        .o_rdata (fifo_rdata),
        .o_empty (fifo_empty)
    );

endmodule

`default_nettype wire

/* tb/tb_fetch.sv */
/*
 * Directed testbench for the fetch front end.
 * Memory words equal their byte address XOR 32'hA5A5_0000.
 * All fetched addresses stay below the cache size, so lines never conflict.
 * Outputs are sampled on the falling edge, inputs change on the rising edge.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch;

    localparam int          LINE_WORDS = `FETCH_IC_LINE_SIZE / 4;
    localparam int          TIMEOUT    = 2000;
    localparam logic [31:0] INSN_KEY   = 32'hA5A5_0000;

    logic                    clk;
    logic                    i_rst_n;
    logic                    i_redirect;
    fetch_pkg::addr_t        i_redirect_addr;
    logic                    i_decode_stall;
    logic                    o_fetch_valid;
    fetch_pkg::addr_t        o_fetch_pc;
    fetch_pkg::insn_t        o_fetch_insn;
    logic                    o_mem_req;
    fetch_pkg::addr_t        o_mem_addr;
    logic                    i_mem_rsp;
    fetch_pkg::line_t        i_mem_data;

    logic [31:0]             lfsr_r;
    int                      stall_mode;
    logic                    stall_prev;
    logic                    mem_busy;
    int                      mem_idle;
    fetch_pkg::addr_t        exp_pc;
    fetch_pkg::addr_t        last_pc;
    fetch_pkg::addr_t        mem_lo;
    fetch_pkg::addr_t        mem_hi;
    int                      out_count;
    int                      mem_req_count;
    int                      mismatch_count;
    int                      error_count;
    logic                    timed_out;

    fetch_top u_fetch_top (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_decode_stall  (i_decode_stall),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_insn    (o_fetch_insn),
        .o_mem_req       (o_mem_req),
        .o_mem_addr      (o_mem_addr),
        .i_mem_rsp       (i_mem_rsp),
        .i_mem_data      (i_mem_data)
    );

    always #50 clk = ~clk;

    // Galois form, taps x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_r = lfsr_next(lfsr_r);
            v = (v << 1) | lfsr_r[0];
        end
    endtask

    function automatic fetch_pkg::line_t make_line(input fetch_pkg::addr_t base);
        fetch_pkg::line_t line;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*32 +: 32] = (base + 4 * w) ^ INSN_KEY;
        end
        return line;
    endfunction

    // Line memory, answers 2 to 9 cycles after each request
    always begin : mem_model
        fetch_pkg::addr_t req_addr;
        int unsigned      delay;
        @(negedge clk);
        if (o_mem_req) begin
            req_addr = o_mem_addr;
            mem_busy = 1'b1;
            take_bits(3, delay);
            repeat (delay + 1) @(posedge clk);
            @(posedge clk);
            i_mem_rsp  <= 1'b1;
            i_mem_data <= make_line(req_addr);
            @(posedge clk);
            i_mem_rsp <= 1'b0;
            mem_busy  <= 1'b0;
        end
    end

    // Mode 0 never stalls, mode 1 stalls at random, mode 2 always stalls
    always @(posedge clk) begin : stall_driver
        int unsigned b;
        case (stall_mode)
            1: begin
                take_bits(1, b);
                i_decode_stall <= b[0];
            end
            2: i_decode_stall <= 1'b1;
            default: i_decode_stall <= 1'b0;
        endcase
    end

    always @(negedge clk) begin : monitor
        if (o_fetch_valid) begin
            assert (o_fetch_pc == exp_pc) else begin
                $display("Mismatch at %0t: o_fetch_pc is %h, expected %h",
                         $time, o_fetch_pc, exp_pc);
                mismatch_count++;
            end
            assert (o_fetch_insn == (exp_pc ^ INSN_KEY)) else begin
                $display("Mismatch at %0t: o_fetch_insn is %h, expected %h",
                         $time, o_fetch_insn, exp_pc ^ INSN_KEY);
                mismatch_count++;
            end
            assert (!stall_prev) else begin
                $display("Error at %0t: output valid right after a decoder stall", $time);
                error_count++;
            end
            last_pc = o_fetch_pc;
            exp_pc  = exp_pc + 4;
            out_count++;
            if (exp_pc + 64 > mem_hi) begin
                mem_hi = exp_pc + 64;
            end
        end
        if (o_mem_req) begin
            mem_req_count++;
            assert (o_mem_addr % `FETCH_IC_LINE_SIZE == 0) else begin
                $display("Error at %0t: memory read address %h is not line aligned",
                         $time, o_mem_addr);
                error_count++;
            end
            assert (o_mem_addr >= mem_lo && o_mem_addr < mem_hi) else begin
                $display("Error at %0t: memory read address %h is outside the fetched range",
                         $time, o_mem_addr);
                error_count++;
            end
        end
        mem_idle   = (o_mem_req || mem_busy) ? 0 : mem_idle + 1;
        stall_prev = i_decode_stall;
    end

    task automatic report_timeout(input string what);
        fetch_pkg::fetch_state_t st;
        st = u_fetch_top.u_fetch_ctrl.state_r;
        $display("Error at %0t: timeout while waiting for %s, fetch FSM in %s",
                 $time, what, st.name());
        error_count++;
        timed_out = 1'b1;
    endtask

    task automatic wait_outputs(input int n, input string what);
        int target;
        int cycles;
        target = out_count + n;
        cycles = 0;
        while (!timed_out && out_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout(what);
            end
        end
    endtask

    task automatic settle_memory(input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && mem_idle < 4) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout(what);
            end
        end
    endtask

    task automatic set_stall_mode(input int mode);
        @(negedge clk);
        stall_mode = mode;
    endtask

    task automatic do_redirect(input fetch_pkg::addr_t target);
        @(posedge clk);
        i_redirect      <= 1'b1;
        i_redirect_addr <= target;
        exp_pc = target;
        if (target + 64 > mem_hi) begin
            mem_hi = target + 64;
        end
        @(posedge clk);
        i_redirect <= 1'b0;
    endtask

    task automatic apply_reset();
        i_rst_n <= 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        assert (!o_fetch_valid && !o_mem_req) else begin
            $display("Error at %0t: fetch or memory request active during reset", $time);
            error_count++;
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
    endtask

    task automatic cold_start();
        mem_lo = 32'h100;
        do_redirect(32'h100);
        wait_outputs(20, "20 outputs after the cold start");
    endtask

    task automatic decode_backpressure();
        set_stall_mode(1);
        wait_outputs(60, "60 outputs under random decoder stalls");
        set_stall_mode(0);
    endtask

    task automatic midstream_redirect();
        wait_outputs(4, "streaming before the redirect");
        mem_lo = 32'h40;
        do_redirect(32'h40);
        wait_outputs(1, "the first output after the redirect");
        assert (last_pc == 32'h40) else begin
            $display("Mismatch at %0t: o_fetch_pc is %h, expected %h", $time, last_pc, 32'h40);
            mismatch_count++;
        end
        // Stream on into cached lines until the memory goes quiet
        wait_outputs(51, "outputs up to 0x10c");
        settle_memory("the memory to go idle");
    endtask

    task automatic cache_reuse();
        int req_start;
        req_start = mem_req_count;
        do_redirect(32'h100);
        wait_outputs(16, "16 outputs from cached lines");
        assert (mem_req_count == req_start) else begin
            $display("Error at %0t: %0d memory reads issued for lines already cached",
                     $time, mem_req_count - req_start);
            error_count++;
        end
    endtask

    task automatic line_cross_full_fifo();
        int out_start;
        set_stall_mode(2);
        do_redirect(32'h1E0);
        out_start = out_count;
        repeat (30) @(posedge clk);
        assert (out_count == out_start) else begin
            $display("Error at %0t: outputs appeared while the decoder was stalled", $time);
            error_count++;
        end
        set_stall_mode(0);
        wait_outputs(20, "20 outputs across the 0x200 line boundary");
        assert (last_pc == 32'h22C) else begin
            $display("Mismatch at %0t: o_fetch_pc is %h, expected %h", $time, last_pc, 32'h22C);
            mismatch_count++;
        end
    endtask

    initial begin
        clk             = 1'b0;
        i_rst_n         = 1'b0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_decode_stall  = 1'b0;
        i_mem_rsp       = 1'b0;
        i_mem_data      = '0;
        lfsr_r          = 32'h1618_01c6;
        stall_mode      = 0;
        stall_prev      = 1'b0;
        mem_busy        = 1'b0;
        mem_idle        = 0;
        exp_pc          = '0;
        last_pc         = '0;
        mem_lo          = '0;
        mem_hi          = '0;
        out_count       = 0;
        mem_req_count   = 0;
        mismatch_count  = 0;
        error_count     = 0;
        timed_out       = 1'b0;

        apply_reset();
        cold_start();
        decode_backpressure();
        midstream_redirect();
        cache_reuse();
        line_cross_full_fifo();
        repeat (4) @(posedge clk);

        $display("Summary: %0d outputs checked, %0d mismatches, %0d other errors",
                 out_count, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/fetch_pkg.sv
source/sync_fifo.sv
source/ifq.sv
fetch/icache.sv
fetch/fetch_ctrl.sv
source/fetch_top.sv
tb/tb_fetch.sv
